// File: design/alu_pkg.sv
package alu_pkg;

	// datapath word, also the width of each half of z
	localparam int word_width = 32;

	// booth iterations, one per multiplier bit
	localparam int mult_steps = 32;

	// width of the booth iteration counter
	localparam int step_cnt_width = $clog2(mult_steps);

	// number of 4-bit lookahead groups in the adder
	localparam int cla_groups = word_width / 4;

	// alu opcodes
	// codes 12 to 15 are unused and give a zero result
	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		// bitwise invert of the bus operand
		op_not  = 4'd4,
		// two's complement of the bus operand
		op_neg  = 4'd5,
		op_shr  = 4'd6,
		op_shra = 4'd7,
		op_shl  = 4'd8,
		op_ror  = 4'd9,
		op_rol  = 4'd10,
		// signed 32x32 -> 64, multi-cycle
		op_mul  = 4'd11
	} alu_op_t;

endpackage

// File: design/alu_shifting.sv
`timescale 1ns/1ns

module alu_shifting (
	input  logic [alu_pkg::word_width-1:0] a,
	input  logic [alu_pkg::word_width-1:0] b,
	input  logic                           shr,
	input  logic                           shra,
	input  logic                           shl,
	input  logic                           ror,
	input  logic                           rol,
	output logic [alu_pkg::word_width-1:0] c
);

	import alu_pkg::*;

	// shr and shra share one chain
	logic [word_width-1:0] shr_out;
	logic [word_width-1:0] shl_out;
	logic [word_width-1:0] ror_out;
	logic [word_width-1:0] rol_out;
	// bit shifted in from the top on right shifts
	logic                  fill;
	// count of 32 or more
	logic                  big;

	assign fill = shra & a[word_width-1];
	assign big  = |b[word_width-1:5];

	// priority select, right shifts first
	always_comb begin
		if (shr | shra)
			c = shr_out;
		else if (shl)
			c = shl_out;
		else if (ror)
			c = ror_out;
		else if (rol)
			c = rol_out;
		else
			c = '0;
	end

	// right shift chain, stages of 1 2 4 8 16
	always_comb begin
		shr_out = '0;
		if (shr | shra) begin
			shr_out = a;
			if (b[0])
				shr_out = {fill, shr_out[word_width-1:1]};
			if (b[1])
				shr_out = {{2{fill}}, shr_out[word_width-1:2]};
			if (b[2])
				shr_out = {{4{fill}}, shr_out[word_width-1:4]};
			if (b[3])
				shr_out = {{8{fill}}, shr_out[word_width-1:8]};
			if (b[4])
				shr_out = {{16{fill}}, shr_out[word_width-1:16]};
			// everything shifted out
			if (big)
				shr_out = {word_width{fill}};
		end
	end

	// left shift chain, zero fill
	always_comb begin
		shl_out = '0;
		if (shl) begin
			shl_out = a;
			if (b[0])
				shl_out = {shl_out[word_width-2:0], 1'b0};
			if (b[1])
				shl_out = {shl_out[word_width-3:0], 2'b0};
			if (b[2])
				shl_out = {shl_out[word_width-5:0], 4'b0};
			if (b[3])
				shl_out = {shl_out[word_width-9:0], 8'b0};
			if (b[4])
				shl_out = {shl_out[word_width-17:0], 16'b0};
			if (big)
				shl_out = '0;
		end
	end

	// rotate right, stages chain on the previous stage
	// upper count bits ignored, a full turn is a no-op
	always_comb begin
		ror_out = '0;
		if (ror) begin
			ror_out = a;
			if (b[0])
				ror_out = {ror_out[0], ror_out[word_width-1:1]};
			if (b[1])
				ror_out = {ror_out[1:0], ror_out[word_width-1:2]};
			if (b[2])
				ror_out = {ror_out[3:0], ror_out[word_width-1:4]};
			if (b[3])
				ror_out = {ror_out[7:0], ror_out[word_width-1:8]};
			if (b[4])
				ror_out = {ror_out[15:0], ror_out[word_width-1:16]};
		end
	end

	// rotate left, same structure mirrored
	always_comb begin
		rol_out = '0;
		if (rol) begin
			rol_out = a;
			if (b[0])
				rol_out = {rol_out[word_width-2:0], rol_out[word_width-1]};
			if (b[1])
				rol_out = {rol_out[word_width-3:0], rol_out[word_width-1:word_width-2]};
			if (b[2])
				rol_out = {rol_out[word_width-5:0], rol_out[word_width-1:word_width-4]};
			if (b[3])
				rol_out = {rol_out[word_width-9:0], rol_out[word_width-1:word_width-8]};
			if (b[4])
				rol_out = {rol_out[word_width-17:0], rol_out[word_width-1:word_width-16]};
		end
	end

endmodule

// File: design/alu_cla_adder.sv
`timescale 1ns/1ns

module alu_cla_adder (
	input  logic [alu_pkg::word_width-1:0] a,
	input  logic [alu_pkg::word_width-1:0] b,
	input  logic                           sub,
	output logic [alu_pkg::word_width-1:0] sum
);

	import alu_pkg::*;

	// b after optional inversion
	logic [word_width-1:0]   bx;
	// bit generate / propagate
	logic [word_width-1:0]   g;
	logic [word_width-1:0]   p;
	// carry into every bit
	logic [word_width-1:0]   c;
	// group generate / propagate, last group has no consumer
	logic [cla_groups-2:0]   gg;
	logic [cla_groups-2:0]   gp;
	// carry into each group
	logic [cla_groups-1:0]   gc;

	assign bx = b ^ {word_width{sub}};
	assign g  = a & bx;
	assign p  = a ^ bx;

	// group lookahead and the ripple between groups
	always_comb begin
		// subtract is a + ~b + 1
		gc[0] = sub;
		for (int i = 0; i < cla_groups - 1; i++) begin
			gg[i] = g[4*i+3] | (p[4*i+3] & g[4*i+2]) |
				(p[4*i+3] & p[4*i+2] & g[4*i+1]) |
				(p[4*i+3] & p[4*i+2] & p[4*i+1] & g[4*i]);
			gp[i] = &p[4*i +: 4];
			gc[i+1] = gg[i] | (gp[i] & gc[i]);
		end
	end

	// carries inside each group, all from the group carry in
	always_comb begin
		for (int i = 0; i < cla_groups; i++) begin
			c[4*i]   = gc[i];
			c[4*i+1] = g[4*i] | (p[4*i] & gc[i]);
			c[4*i+2] = g[4*i+1] | (p[4*i+1] & g[4*i]) |
				(p[4*i+1] & p[4*i] & gc[i]);
			c[4*i+3] = g[4*i+2] | (p[4*i+2] & g[4*i+1]) |
				(p[4*i+2] & p[4*i+1] & g[4*i]) |
				(p[4*i+2] & p[4*i+1] & p[4*i] & gc[i]);
		end
	end

	assign sum = p ^ c;

endmodule

// File: design/alu_booth_mult.sv
`timescale 1ns/1ns

module alu_booth_mult (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             start,
	input  logic [alu_pkg::word_width-1:0]   multiplicand,
	input  logic [alu_pkg::word_width-1:0]   multiplier,
	output logic                             busy,
	output logic                             done,
	output logic [2*alu_pkg::word_width-1:0] product
);

	import alu_pkg::*;

	// upper half, one guard bit so that adding the most
	// negative multiplicand cannot overflow
	logic [word_width:0]     acc;
	// lower half, starts as the multiplier
	logic [word_width-1:0]   q;
	// booth bit to the right of q[0]
	logic                    q_m1;
	logic [word_width-1:0]   mcand;
	// sign extended multiplicand
	logic [word_width:0]     mcand_x;
	// upper half after this step's add or subtract
	logic [word_width:0]     acc_sum;
	logic                    running;
	logic                    done_r;
	logic [step_cnt_width-1:0] count;
	logic                    accept;

	assign accept  = start & ~busy;
	assign mcand_x = {mcand[word_width-1], mcand};

	// recode the low bit pair
	always_comb begin
		case ({q[0], q_m1})
			// end of a run of ones
			2'b01:   acc_sum = acc + mcand_x;
			// start of a run of ones
			2'b10:   acc_sum = acc - mcand_x;
			default: acc_sum = acc;
		endcase
	end

	// sequencing
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			done_r  <= 1'b0;
			count   <= '0;
		end else begin
			done_r <= 1'b0;
			if (accept) begin
				running <= 1'b1;
				count   <= '0;
			end else if (running) begin
				count <= count + 1'b1;
				// last iteration, product valid next cycle
				if (count == step_cnt_width'(mult_steps - 1)) begin
					running <= 1'b0;
					done_r  <= 1'b1;
				end
			end
		end
	end

	// datapath, add then arithmetic shift right of {acc, q, q_m1}
	always_ff @(posedge clk) begin
		if (accept) begin
			acc   <= '0;
			q     <= multiplier;
			q_m1  <= 1'b0;
			mcand <= multiplicand;
		end else if (running) begin
			{acc, q, q_m1} <= {acc_sum[word_width], acc_sum, q};
		end
	end

	// busy stays up through the done cycle so
	// the result can be handed over before a new start
	assign busy    = running | done_r;
	assign done    = done_r;
	assign product = {acc[word_width-1:0], q};

endmodule

// File: design/alu_result_stage.sv
`timescale 1ns/1ns

module alu_result_stage (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [alu_pkg::word_width-1:0]   bus_in,
	input  logic                             y_load,
	input  alu_pkg::alu_op_t                 op,
	input  logic                             op_valid,
	// adder side
	output logic [alu_pkg::word_width-1:0]   add_a,
	output logic [alu_pkg::word_width-1:0]   add_b,
	output logic                             add_sub,
	input  logic [alu_pkg::word_width-1:0]   add_sum,
	// shifter side
	output logic [alu_pkg::word_width-1:0]   shift_a,
	output logic [alu_pkg::word_width-1:0]   shift_b,
	output logic                             shr,
	output logic                             shra,
	output logic                             shl,
	output logic                             ror,
	output logic                             rol,
	input  logic [alu_pkg::word_width-1:0]   shift_c,
	// multiplier side
	output logic                             mult_start,
	input  logic                             mult_busy,
	input  logic                             mult_done,
	input  logic [2*alu_pkg::word_width-1:0] mult_product,
	// results
	output logic [alu_pkg::word_width-1:0]   z_hi,
	output logic [alu_pkg::word_width-1:0]   z_lo,
	output logic                             done,
	output logic                             busy
);

	import alu_pkg::*;

	// operand a register
	logic [word_width-1:0] y;
	// single-cycle result for the current op
	logic [word_width-1:0] result;
	// op_valid that is taken, not dropped for busy
	logic                  accept;
	logic                  is_mul;

	// busy spans the whole mul, done cycle included
	assign busy   = mult_busy;
	assign accept = op_valid & ~busy;
	assign is_mul = (op == op_mul);

	assign mult_start = accept & is_mul;

	// adder controls
	// neg is 0 - b
	assign add_a   = (op == op_neg) ? '0 : y;
	assign add_b   = bus_in;
	assign add_sub = (op == op_sub) | (op == op_neg);

	// shifter operands and one-hot kind
	assign shift_a = y;
	assign shift_b = bus_in;
	assign shr     = (op == op_shr);
	assign shra    = (op == op_shra);
	assign shl     = (op == op_shl);
	assign ror     = (op == op_ror);
	assign rol     = (op == op_rol);

	// result mux, logic ops done here
	always_comb begin
		case (op)
			op_add, op_sub, op_neg:
				result = add_sum;
			op_and:
				result = y & bus_in;
			op_or:
				result = y | bus_in;
			// not takes the bus operand
			op_not:
				result = ~bus_in;
			op_shr, op_shra, op_shl, op_ror, op_rol:
				result = shift_c;
			// mul and undefined codes
			default:
				result = '0;
		endcase
	end

	// y and z registers, done pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			y    <= '0;
			z_hi <= '0;
			z_lo <= '0;
			done <= 1'b0;
		end else begin
			// same-edge op still sees old y
			if (y_load)
				y <= bus_in;
			done <= 1'b0;
			if (accept && !is_mul) begin
				z_hi <= '0;
				z_lo <= result;
				done <= 1'b1;
			end else if (mult_done) begin
				// busy is high here, no accept can collide
				{z_hi, z_lo} <= mult_product;
				done         <= 1'b1;
			end
		end
	end

endmodule

// File: design/alu_unit.sv
`timescale 1ns/1ns

module alu_unit (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [alu_pkg::word_width-1:0] bus_in,
	input  logic                           y_load,
	input  alu_pkg::alu_op_t               op,
	input  logic                           op_valid,
	output logic [alu_pkg::word_width-1:0] z_hi,
	output logic [alu_pkg::word_width-1:0] z_lo,
	output logic                           done,
	output logic                           busy
);

	import alu_pkg::*;

	// adder hookup
	logic [word_width-1:0]   add_a;
	logic [word_width-1:0]   add_b;
	logic                    add_sub;
	logic [word_width-1:0]   add_sum;
	// shifter hookup
	logic [word_width-1:0]   shift_a;
	logic [word_width-1:0]   shift_b;
	logic                    shr;
	logic                    shra;
	logic                    shl;
	logic                    ror;
	logic                    rol;
	logic [word_width-1:0]   shift_c;
	// multiplier hookup
	logic                    mult_start;
	logic                    mult_busy;
	logic                    mult_done;
	logic [2*word_width-1:0] mult_product;

	// control, y, z
	alu_result_stage u_result (
		.clk          (clk),
		.rst          (rst),
		.bus_in       (bus_in),
		.y_load       (y_load),
		.op           (op),
		.op_valid     (op_valid),
		.add_a        (add_a),
		.add_b        (add_b),
		.add_sub      (add_sub),
		.add_sum      (add_sum),
		.shift_a      (shift_a),
		.shift_b      (shift_b),
		.shr          (shr),
		.shra         (shra),
		.shl          (shl),
		.ror          (ror),
		.rol          (rol),
		.shift_c      (shift_c),
		.mult_start   (mult_start),
		.mult_busy    (mult_busy),
		.mult_done    (mult_done),
		.mult_product (mult_product),
		.z_hi         (z_hi),
		.z_lo         (z_lo),
		.done         (done),
		.busy         (busy)
	);

	alu_cla_adder u_adder (
		.a   (add_a),
		.b   (add_b),
		.sub (add_sub),
		.sum (add_sum)
	);

	alu_shifting u_shifter (
		.a    (shift_a),
		.b    (shift_b),
		.shr  (shr),
		.shra (shra),
		.shl  (shl),
		.ror  (ror),
		.rol  (rol),
		.c    (shift_c)
	);

	// multiplier takes y as multiplicand, bus as multiplier
	alu_booth_mult u_mult (
		.clk          (clk),
		.rst          (rst),
		.start        (mult_start),
		.multiplicand (shift_a),
		.multiplier   (shift_b),
		.busy         (mult_busy),
		.done         (mult_done),
		.product      (mult_product)
	);

endmodule

// File: dv/alu_tb.sv
`timescale 1ns/1ns

module alu_tb;

	import alu_pkg::*;

	// run length bound, worst case op plus drive and check cycles
	localparam int max_ops     = 400;
	localparam int cycle_limit = max_ops * (mult_steps + 3) + 2000;
	// cycles to wait for done before giving up on one op
	localparam int done_wait   = mult_steps + 8;

	logic                  clk;
	logic                  rst;
	logic [word_width-1:0] bus_in;
	logic                  y_load;
	alu_op_t               op;
	logic                  op_valid;
	logic [word_width-1:0] z_hi;
	logic [word_width-1:0] z_lo;
	logic                  done;
	logic                  busy;

	// operand source, fibonacci lfsr x^32+x^22+x^2+x+1
	logic [31:0] lfsr = 32'h88be2a16;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycles = 0;

	alu_unit dut (
		.clk      (clk),
		.rst      (rst),
		.bus_in   (bus_in),
		.y_load   (y_load),
		.op       (op),
		.op_valid (op_valid),
		.z_hi     (z_hi),
		.z_lo     (z_lo),
		.done     (done),
		.busy     (busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	// expected {z_hi, z_lo}, a is y and b is the bus operand
	function automatic logic [2*word_width-1:0] predict(input alu_op_t o,
			input logic [word_width-1:0] a, input logic [word_width-1:0] b);
		logic signed [2*word_width-1:0] sa;
		logic signed [2*word_width-1:0] sb;
		logic [word_width-1:0]          r;
		int                             n;
		sa = $signed(a);
		sb = $signed(b);
		// rotate amount wraps at the word size
		n  = b % word_width;
		case (o)
			op_add:  r = a + b;
			op_sub:  r = a - b;
			op_neg:  r = 32'd0 - b;
			op_and:  r = a & b;
			op_or:   r = a | b;
			op_not:  r = ~b;
			op_shr:  r = (b >= word_width) ? '0 : a >> b;
			// sign fill
			op_shra: begin
				if (b >= word_width)
					r = {word_width{a[31]}};
				else
					r = $signed(a) >>> b;
			end
			op_shl:  r = (b >= word_width) ? '0 : a << b;
			op_ror:  r = (n == 0) ? a : (a >> n) | (a << (word_width - n));
			op_rol:  r = (n == 0) ? a : (a << n) | (a >> (word_width - n));
			default: r = '0;
		endcase
		if (o == op_mul)
			return sa * sb;
		return {{word_width{1'b0}}, r};
	endfunction

	task automatic load_y(input logic [word_width-1:0] v);
		@(posedge clk);
		bus_in <= v;
		y_load <= 1'b1;
		@(posedge clk);
		y_load <= 1'b0;
	endtask

	// issue one op, y must already hold a
	// also_load raises y_load at the same edge
	task automatic exec_op(input alu_op_t o, input logic [word_width-1:0] a,
			input logic [word_width-1:0] b, input logic also_load);
		logic [2*word_width-1:0] exp;
		int                      exp_lat;
		int                      lat;
		exp     = predict(o, a, b);
		// edges after the accepting edge until the one that raises done
		exp_lat = (o == op_mul) ? mult_steps + 1 : 0;
		@(posedge clk);
		bus_in   <= b;
		op       <= o;
		op_valid <= 1'b1;
		y_load   <= also_load;
		// accepting edge
		@(posedge clk);
		op_valid <= 1'b0;
		y_load   <= 1'b0;
		@(negedge clk);
		lat = 0;
		while (!done && lat < done_wait) begin
			@(negedge clk);
			lat++;
		end
		if (!done) begin
			$display("op %0d at %0t: done never came", o, $time);
			errors++;
		end else begin
			if (lat != exp_lat) begin
				$display("[ERROR] %0t: done latency expected %0d, actual %0d (op %0d)",
					$time, exp_lat, lat, o);
				errors++;
			end
			if (z_hi != exp[2*word_width-1:word_width]) begin
				$display("[ERROR] %0t: z_hi expected %h, actual %h (op %0d)",
					$time, exp[2*word_width-1:word_width], z_hi, o);
				errors++;
			end
			if (z_lo != exp[word_width-1:0]) begin
				$display("[ERROR] %0t: z_lo expected %h, actual %h (op %0d)",
					$time, exp[word_width-1:0], z_lo, o);
				errors++;
			end
			// pulse is one cycle wide
			@(negedge clk);
			if (done) begin
				$display("[ERROR] %0t: done expected 0, actual %b (op %0d)",
					$time, done, o);
				errors++;
			end
		end
	endtask

	task automatic run_op(input alu_op_t o, input logic [word_width-1:0] a,
			input logic [word_width-1:0] b);
		load_y(a);
		exec_op(o, a, b, 1'b0);
	endtask

	task automatic random_ops(input alu_op_t o, input int count);
		logic [word_width-1:0] a;
		logic [word_width-1:0] b;
		for (int n = 0; n < count; n++) begin
			a = rand_bits(32);
			b = rand_bits(32);
			run_op(o, a, b);
		end
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		if (errors == errs_at_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errs_at_start);
		end
	endtask

	task automatic reset_state();
		int errs_at_start;
		errs_at_start = errors;
		@(negedge clk);
		if (done || busy) begin
			$display("[ERROR] %0t: done/busy expected 0/0, actual %b/%b", $time, done, busy);
			errors++;
		end
		if (z_hi != '0 || z_lo != '0) begin
			$display("[ERROR] %0t: z expected 0, actual %h_%h", $time, z_hi, z_lo);
			errors++;
		end
		// y still zero from reset
		exec_op(op_add, '0, rand_bits(32), 1'b0);
		finish_test("reset", errs_at_start);
	endtask

	task automatic arith_ops();
		int errs_at_start;
		errs_at_start = errors;
		random_ops(op_add, 60);
		random_ops(op_sub, 60);
		random_ops(op_neg, 60);
		finish_test("arith", errs_at_start);
	endtask

	task automatic logic_ops();
		int errs_at_start;
		errs_at_start = errors;
		random_ops(op_and, 15);
		random_ops(op_or, 15);
		random_ops(op_not, 15);
		// unused codes
		for (int c = 12; c < 16; c++)
			random_ops(alu_op_t'(c), 1);
		finish_test("logic", errs_at_start);
	endtask

	task automatic shift_ops();
		alu_op_t               kinds [5];
		logic [word_width-1:0] counts [5];
		logic [word_width-1:0] a;
		logic [word_width-1:0] b;
		int                    errs_at_start;
		errs_at_start = errors;
		kinds  = '{op_shr, op_shra, op_shl, op_ror, op_rol};
		counts = '{32'd0, 32'd1, 32'd31, 32'd32, 32'hc000_0025};
		foreach (kinds[k]) begin
			for (int n = 0; n < 10; n++) begin
				a = rand_bits(32);
				b = rand_bits(5);
				run_op(kinds[k], a, b);
			end
			// negative then positive operand, so shra fills both ways
			foreach (counts[j]) begin
				run_op(kinds[k], rand_bits(32) | 32'h8000_0000, counts[j]);
				run_op(kinds[k], rand_bits(32) & 32'h7fff_ffff, counts[j]);
			end
		end
		finish_test("shift", errs_at_start);
	endtask

	task automatic mul_ops();
		int errs_at_start;
		errs_at_start = errors;
		run_op(op_mul, '0, rand_bits(32));
		run_op(op_mul, rand_bits(32), '0);
		run_op(op_mul, 32'hffff_ffff, 32'hffff_ffff);
		run_op(op_mul, 32'hffff_ffff, rand_bits(32));
		// most negative squared, and its mixes
		run_op(op_mul, 32'h8000_0000, 32'h8000_0000);
		run_op(op_mul, 32'h8000_0000, 32'hffff_ffff);
		run_op(op_mul, 32'h7fff_ffff, 32'h8000_0000);
		run_op(op_mul, rand_bits(32) & 32'h7fff_ffff, rand_bits(32) | 32'h8000_0000);
		run_op(op_mul, rand_bits(32) | 32'h8000_0000, rand_bits(32) & 32'h7fff_ffff);
		random_ops(op_mul, 20);
		finish_test("mul", errs_at_start);
	endtask

	task automatic busy_strobes();
		logic [word_width-1:0]   a;
		logic [word_width-1:0]   b;
		logic [word_width-1:0]   new_y;
		logic [2*word_width-1:0] prod;
		int                      dones;
		int                      done_at;
		int                      errs_at_start;
		errs_at_start = errors;
		a       = rand_bits(32);
		b       = rand_bits(32);
		new_y   = rand_bits(32);
		prod    = predict(op_mul, a, b);
		dones   = 0;
		done_at = 0;
		load_y(a);
		@(posedge clk);
		bus_in   <= b;
		op       <= op_mul;
		op_valid <= 1'b1;
		@(posedge clk);
		op_valid <= 1'b0;
		// edge i of the mul, strobes set here land on edge i+1
		for (int i = 1; i <= 40; i++) begin
			@(posedge clk);
			if (i == 2) begin
				bus_in   <= new_y;
				y_load   <= 1'b1;
				op       <= op_sub;
				op_valid <= 1'b1;
			end else if (i == 3) begin
				y_load <= 1'b0;
				op     <= op_shl;
				bus_in <= rand_bits(32);
			end else if (i == 32) begin
				// lands on the done cycle, busy still high
				op <= op_and;
			end else if (i == 33) begin
				op_valid <= 1'b0;
			end
			@(negedge clk);
			if (done) begin
				dones++;
				if (dones == 1)
					done_at = i;
			end
			if (i == 32 && !busy) begin
				$display("[ERROR] %0t: busy expected 1, actual %b", $time, busy);
				errors++;
			end
			if (i == 33 && busy) begin
				$display("[ERROR] %0t: busy expected 0, actual %b", $time, busy);
				errors++;
			end
		end
		if (dones != 1) begin
			$display("[ERROR] %0t: done pulses expected 1, actual %0d", $time, dones);
			errors++;
		end
		if (done_at != mult_steps + 1) begin
			$display("[ERROR] %0t: done latency expected %0d, actual %0d",
				$time, mult_steps + 1, done_at);
			errors++;
		end
		if ({z_hi, z_lo} != prod) begin
			$display("[ERROR] %0t: z expected %h, actual %h", $time, prod, {z_hi, z_lo});
			errors++;
		end
		// y was reloaded while busy
		exec_op(op_add, new_y, rand_bits(32), 1'b0);
		// same-edge load and op, op sees the old y
		a = rand_bits(32);
		b = rand_bits(32);
		load_y(a);
		exec_op(op_add, a, b, 1'b1);
		exec_op(op_or, b, rand_bits(32), 1'b0);
		finish_test("busy", errs_at_start);
	endtask

	initial begin
		rst      = 1'b1;
		bus_in   = '0;
		y_load   = 1'b0;
		op       = op_add;
		op_valid = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		reset_state();
		arith_ops();
		logic_ops();
		shift_ops();
		mul_ops();
		busy_strobes();
		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: alu_unit.f
design/alu_pkg.sv
design/alu_shifting.sv
design/alu_cla_adder.sv
design/alu_booth_mult.sv
design/alu_result_stage.sv
design/alu_unit.sv
dv/alu_tb.sv

// File: Bender.yml
package:
  name: alu_unit

sources:
  # package first, then the leaf blocks, then the top
  - files:
      - design/alu_pkg.sv
      - design/alu_shifting.sv
      - design/alu_cla_adder.sv
      - design/alu_booth_mult.sv
      - design/alu_result_stage.sv
      - design/alu_unit.sv
  # testbench, simulation only
  - target: test
    files:
      - dv/alu_tb.sv
